// File: cavlc_input.txt
# total_coeff trailing_ones word_count words(hex) level[0] .. level[15]
# the words of all lines form one continuous bitstream
1 1 2 b800 0900 -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 2 0 -1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 3 0 1 -1 -1 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 2 0080 9800 -40 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 1 0808 -25 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
12 1 5 a188 2468 4623 4102 7459 5 -3 200 -1 100 -50 30 -13 7 -4 2 1 0 0 0 0
4 2 1 1167 -2 3 1 -1 0 0 0 0 0 0 0 0 0 0 0 0
4 3 0 1 -1 1 1 0 0 0 0 0 0 0 0 0 0 0 0

// File: tb.f
+incdir+.
cavlc_pkg.sv
cavlc_bit_window.sv
cavlc_level_ctrl.sv
cavlc_read_levels.sv
cavlc_level_decoder.sv
cavlc_checker.sv
tb_cavlc.sv

// File: Makefile
TOOL       = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = tb_cavlc
FILELIST   = tb.f
LOG        = sim.log
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cavlc.sv
`default_nettype none

`include "cavlc_defines.svh"

module tb_cavlc;

    timeunit 1ns;
    timeprecision 1ps;

    import cavlc_pkg::*;

    localparam int MAX_BLOCKS    = 32;
    localparam int SPACE_TIMEOUT = 500;
    localparam int DONE_TIMEOUT  = 2000;

    logic                    clk;
    logic                    rst_n;
    logic [`CAVLC_WIN_W-1:0] word;
    logic                    word_wr;
    logic                    space;
    logic                    start;
    coeff_cnt_t              total_coeff;
    t1_cnt_t                 trailing_ones;
    level_t                  level [`CAVLC_MAX_COEFF];
    logic                    busy;
    logic                    done;

    level_t                  exp_lv [`CAVLC_MAX_COEFF];
    int                      test_num;
    int                      tests_passed;
    int                      tests_failed;

    // blocks read from the data file
    int                      n_blocks;
    int                      blk_tc [MAX_BLOCKS];
    int                      blk_t1 [MAX_BLOCKS];
    level_t                  blk_exp [MAX_BLOCKS][`CAVLC_MAX_COEFF];
    logic [`CAVLC_WIN_W-1:0] stream [$];
    integer                  seed;

    cavlc_level_decoder UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .word          (word),
        .word_wr       (word_wr),
        .space         (space),
        .start         (start),
        .total_coeff   (total_coeff),
        .trailing_ones (trailing_ones),
        .level         (level),
        .busy          (busy),
        .done          (done)
    );

    cavlc_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .busy         (busy),
        .done         (done),
        .level        (level),
        .expected     (exp_lv),
        .test_num     (test_num),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // data file
    // ----------------------------------------------------------------------

    task automatic read_blocks();
        int    fd;
        int    code;
        int    nw;
        int    val;
        string tok;
        string line;
        logic [`CAVLC_WIN_W-1:0] w;
        fd = $fopen("cavlc_input.txt", "r");
        n_blocks = 0;
        if (fd == 0) begin
            $display("could not open cavlc_input.txt");
            return;
        end
        while (!$feof(fd) && n_blocks < MAX_BLOCKS) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
                break;
            if (tok[0] == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            blk_tc[n_blocks] = tok.atoi();
            code = $fscanf(fd, "%d %d", blk_t1[n_blocks], nw);
            for (int k = 0; k < nw; k++) begin
                code = $fscanf(fd, "%h", w);
                stream.push_back(w);
            end
            for (int k = 0; k < `CAVLC_MAX_COEFF; k++) begin
                code = $fscanf(fd, "%d", val);
                blk_exp[n_blocks][k] = level_t'(val);
            end
            n_blocks++;
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // word feeding
    // ----------------------------------------------------------------------

    task automatic feed_word(input logic [`CAVLC_WIN_W-1:0] w, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        // one edge after the last write so space includes it
        @(posedge clk);
        while (!space) begin
            if (waited >= SPACE_TIMEOUT) begin
                ok = 1'b0;
                return;
            end
            @(posedge clk);
            waited++;
        end
        word    <= w;
        word_wr <= 1'b1;
        @(posedge clk);
        word_wr <= 1'b0;
    endtask

    // random gaps let the window run dry in the middle of a block
    task automatic feed_words();
        int   gap;
        logic ok;
        foreach (stream[n]) begin
            gap = int'($unsigned($random(seed)) % 4);
            repeat (gap) @(posedge clk);
            feed_word(stream[n], ok);
            if (!ok) begin
                chk.report_stall(n);
                return;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // block sequencing
    // ----------------------------------------------------------------------

    task automatic run_block(input int b);
        int waited;
        logic got;
        @(posedge clk);
        exp_lv        = blk_exp[b];
        test_num      = b + 1;
        total_coeff   <= coeff_cnt_t'(blk_tc[b]);
        trailing_ones <= t1_cnt_t'(blk_t1[b]);
        start         <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            if (done)
                got = 1'b1;
            else
                waited++;
        end
        if (!got)
            chk.report_missing_done(test_num, DONE_TIMEOUT);
    endtask

    initial begin
        rst_n         = 1'b0;
        word          = '0;
        word_wr       = 1'b0;
        start         = 1'b0;
        total_coeff   = '0;
        trailing_ones = '0;
        test_num      = 0;
        seed          = 32'h4ffe;
        for (int k = 0; k < `CAVLC_MAX_COEFF; k++)
            exp_lv[k] = '0;

        read_blocks();
        // padding so the last block always sees a full window
        stream.push_back(16'hffff);
        stream.push_back(16'hffff);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        fork
            feed_words();
        join_none

        for (int b = 0; b < n_blocks; b++)
            run_block(b);

        @(posedge clk);
        $display("tests run %0d, passed %0d, failed %0d",
                 n_blocks, tests_passed, tests_failed);
        if (n_blocks > 0 && tests_failed == 0 && tests_passed == n_blocks) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cavlc_checker.sv
`default_nettype none

`include "cavlc_defines.svh"

module cavlc_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                busy,
    input  logic                done,
    input  cavlc_pkg::level_t   level [`CAVLC_MAX_COEFF],
    input  cavlc_pkg::level_t   expected [`CAVLC_MAX_COEFF],
    input  int                  test_num,
    output int                  tests_passed,
    output int                  tests_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    import cavlc_pkg::*;

    int n_pass   = 0;
    int n_fail   = 0;
    int n_missed = 0;
    int n_stall  = 0;

    logic start_d  = 1'b0;
    logic busy_bad = 1'b0;

    assign tests_passed = n_pass;
    assign tests_failed = n_fail + n_missed + n_stall;

    // ----------------------------------------------------------------------
    // busy around start and level compare at done
    // ----------------------------------------------------------------------

    // levels are registered, so the edge that sees done sees final values
    always @(posedge clk) begin
        int bad;
        bad = 0;
        if (rst_n) begin
            // idle when start is taken, busy on the cycle after
            if (start && busy) begin
                $display("test %0d: busy was still high when start was given", test_num);
                busy_bad = 1'b1;
            end
            if (start_d && !busy) begin
                $display("test %0d: busy did not rise after start", test_num);
                busy_bad = 1'b1;
            end
        end
        start_d = start;
        if (rst_n && done) begin
            for (int k = 0; k < `CAVLC_MAX_COEFF; k++) begin
                if (level[k] !== expected[k]) begin
                    $display("mismatch at %0t: test %0d level[%0d] is %0d, expected %0d",
                             $time, test_num, k, level[k], expected[k]);
                    bad++;
                end
            end
            if (busy_bad)
                bad++;
            busy_bad = 1'b0;
            if (bad == 0) begin
                n_pass++;
                $display("test %0d passed", test_num);
            end else begin
                n_fail++;
                $display("test %0d failed with %0d errors", test_num, bad);
            end
        end
    end

    // ----------------------------------------------------------------------
    // failures seen by the stimulus side
    // ----------------------------------------------------------------------

    task automatic report_missing_done(input int t, input int cycles);
        n_missed++;
        $display("test %0d failed: done did not arrive within %0d cycles", t, cycles);
    endtask

    task automatic report_stall(input int n);
        n_stall++;
        $display("bit window had no space for word %0d, feeding stopped", n);
    endtask

endmodule

`default_nettype wire

// File: cavlc_level_decoder.sv
`default_nettype none

`include "cavlc_defines.svh"

module cavlc_level_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CAVLC_WIN_W-1:0] word,
    input  logic                    word_wr,
    output logic                    space,
    input  logic                    start,
    input  cavlc_pkg::coeff_cnt_t   total_coeff,
    input  cavlc_pkg::t1_cnt_t      trailing_ones,
    output cavlc_pkg::level_t       level [`CAVLC_MAX_COEFF],
    output logic                    busy,
    output logic                    done
);

    import cavlc_pkg::*;

    logic [0:`CAVLC_WIN_W-1] bits;
    logic                    bits_ok;
    logic                    ena;
    logic                    t1s_sel;
    logic                    prefix_sel;
    logic                    suffix_sel;
    logic                    calc_sel;
    logic                    clear;
    coeff_idx_t              i;
    coeff_cnt_t              blk_total_coeff;
    t1_cnt_t                 blk_trailing_ones;
    len_t                    len_comb;

    cavlc_bit_window u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .word     (word),
        .word_wr  (word_wr),
        .ena      (ena),
        .len_comb (len_comb),
        .bits     (bits),
        .bits_ok  (bits_ok),
        .space    (space)
    );

    cavlc_level_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .total_coeff       (total_coeff),
        .trailing_ones     (trailing_ones),
        .bits_ok           (bits_ok),
        .ena               (ena),
        .t1s_sel           (t1s_sel),
        .prefix_sel        (prefix_sel),
        .suffix_sel        (suffix_sel),
        .calc_sel          (calc_sel),
        .clear             (clear),
        .i                 (i),
        .blk_total_coeff   (blk_total_coeff),
        .blk_trailing_ones (blk_trailing_ones),
        .busy              (busy),
        .done              (done)
    );

    cavlc_read_levels u_levels (
        .clk           (clk),
        .rst_n         (rst_n),
        .ena           (ena),
        .clear         (clear),
        .t1s_sel       (t1s_sel),
        .prefix_sel    (prefix_sel),
        .suffix_sel    (suffix_sel),
        .calc_sel      (calc_sel),
        .trailing_ones (blk_trailing_ones),
        .total_coeff   (blk_total_coeff),
        .bits          (bits),
        .i             (i),
        .level         (level),
        .len_comb      (len_comb)
    );

endmodule

`default_nettype wire

// File: cavlc_read_levels.sv
`default_nettype none

`include "cavlc_defines.svh"

module cavlc_read_levels (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ena,
    input  logic                    clear,
    input  logic                    t1s_sel,
    input  logic                    prefix_sel,
    input  logic                    suffix_sel,
    input  logic                    calc_sel,
    input  cavlc_pkg::t1_cnt_t      trailing_ones,
    input  cavlc_pkg::coeff_cnt_t   total_coeff,
    input  logic [0:`CAVLC_WIN_W-1] bits,
    input  cavlc_pkg::coeff_idx_t   i,
    output cavlc_pkg::level_t       level [`CAVLC_MAX_COEFF],
    output cavlc_pkg::len_t         len_comb
);

    import cavlc_pkg::*;

    // wide enough for a 15 prefix shifted by 6 plus a 12-bit suffix
    localparam int CODE_W = 13;

    logic [0:`CAVLC_WIN_W-1] bits_int;
    logic [3:0]              prefix_comb;
    logic [3:0]              level_prefix;
    logic [2:0]              suffix_len;
    logic [11:0]             level_suffix;
    logic [CODE_W-1:0]       level_code;
    logic [CODE_W-1:0]       level_mag;
    logic [CODE_W-1:0]       level_abs;
    logic [CODE_W-1:0]       abs_limit;
    logic [1:0]              first_bonus;
    coeff_idx_t              first_idx;
    logic                    first_level;
    level_t                  level_val;

    function automatic level_t sign_one(input logic neg);
        return neg ? level_t'(-1) : level_t'(1);
    endfunction

    // all ones outside read steps keeps the prefix logic quiet
    assign bits_int = ((t1s_sel || prefix_sel || suffix_sel) && ena) ? bits : '1;

    // ----------------------------------------------------------------------
    // level prefix
    // ----------------------------------------------------------------------

    // leading zeros before the first one
    always_comb begin
        prefix_comb = 4'd15;
        for (int k = `CAVLC_WIN_W - 1; k >= 0; k--) begin
            if (bits_int[k])
                prefix_comb = k[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (prefix_sel && ena)
            level_prefix <= prefix_comb;
    end

    // ----------------------------------------------------------------------
    // suffix length
    // ----------------------------------------------------------------------

    assign first_idx   = coeff_idx_t'(total_coeff - coeff_cnt_t'(trailing_ones) - 5'd1);
    assign first_level = i == first_idx;
    assign abs_limit   = CODE_W'(3) << (suffix_len - 3'd1);

    // grows from the previous level, looked at before the next prefix
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            suffix_len <= '0;
        end else if (prefix_sel && ena) begin
            if (first_level)
                suffix_len <= (total_coeff > 5'd10 && trailing_ones < 2'd3) ? 3'd1 : 3'd0;
            else if (suffix_len == 3'd0)
                suffix_len <= (level_abs > CODE_W'(3)) ? 3'd2 : 3'd1;
            else if (level_abs > abs_limit && suffix_len < 3'd6)
                suffix_len <= suffix_len + 3'd1;
        end
    end

    // ----------------------------------------------------------------------
    // level suffix and level code
    // ----------------------------------------------------------------------

    always_comb begin
        if (level_prefix == 4'd15)
            level_suffix = bits_int[0:11];
        else if (suffix_len != 3'd0)
            level_suffix = 12'(bits_int[0:5] >> (3'd6 - suffix_len));
        else if (level_prefix == 4'd14)
            level_suffix = 12'(bits_int[0:3]);
        else
            level_suffix = '0;
    end

    always_ff @(posedge clk) begin
        if (suffix_sel && ena)
            level_code <= (CODE_W'(level_prefix) << suffix_len) + CODE_W'(level_suffix)
                        + ((suffix_len == 3'd0 && level_prefix == 4'd15) ? CODE_W'(15) : '0);
    end

    // first level can't be magnitude 1 when fewer than three trailing ones
    assign first_bonus = (first_level && trailing_ones < 2'd3) ? 2'd2 : 2'd0;

    // even codes are positive, odd codes negative
    assign level_mag = level_code[0] ? (level_code + CODE_W'(first_bonus) + 1'b1) >> 1
                                     : (level_code + CODE_W'(first_bonus) + 2'd2) >> 1;
    assign level_val = level_code[0] ? level_t'(-level_mag) : level_t'(level_mag);

    always_ff @(posedge clk) begin
        if (calc_sel && ena)
            level_abs <= level_mag;
    end

    // ----------------------------------------------------------------------
    // level register file
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `CAVLC_MAX_COEFF; k++)
                level[k] <= '0;
        end else if (clear) begin
            for (int k = 0; k < `CAVLC_MAX_COEFF; k++)
                level[k] <= '0;
        end else if (t1s_sel && ena) begin
            level[i] <= sign_one(bits_int[0]);
            if (trailing_ones[1])
                level[i - 4'd1] <= sign_one(bits_int[1]);
            if (trailing_ones == 2'd3)
                level[i - 4'd2] <= sign_one(bits_int[2]);
        end else if (calc_sel && ena) begin
            level[i] <= level_val;
        end
    end

    // ----------------------------------------------------------------------
    // bits used by this step
    // ----------------------------------------------------------------------

    always_comb begin
        len_comb = '0;
        if (t1s_sel) begin
            len_comb = len_t'(trailing_ones);
        end else if (prefix_sel) begin
            len_comb = len_t'(prefix_comb) + 5'd1;
        end else if (suffix_sel) begin
            if (level_prefix == 4'd15)
                len_comb = 5'd12;
            else if (suffix_len != 3'd0)
                len_comb = len_t'(suffix_len);
            else if (level_prefix == 4'd14)
                len_comb = 5'd4;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) suffix_len <= 3'd6)
        else $error("suffixLength out of range: %0d", suffix_len);

endmodule

`default_nettype wire

// File: cavlc_level_ctrl.sv
`default_nettype none

module cavlc_level_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  cavlc_pkg::coeff_cnt_t   total_coeff,
    input  cavlc_pkg::t1_cnt_t      trailing_ones,
    input  logic                    bits_ok,
    output logic                    ena,
    output logic                    t1s_sel,
    output logic                    prefix_sel,
    output logic                    suffix_sel,
    output logic                    calc_sel,
    output logic                    clear,
    output cavlc_pkg::coeff_idx_t   i,
    output cavlc_pkg::coeff_cnt_t   blk_total_coeff,
    output cavlc_pkg::t1_cnt_t      blk_trailing_ones,
    output logic                    busy,
    output logic                    done
);

    import cavlc_pkg::*;

    lvl_state_t state;
    lvl_state_t state_nxt;
    logic       start_ok;
    logic       all_t1s;

    assign start_ok = (state == ST_IDLE) && start;
    assign all_t1s  = blk_total_coeff == coeff_cnt_t'(blk_trailing_ones);

    // ----------------------------------------------------------------------
    // state register
    // ----------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    if (total_coeff == '0)
                        state_nxt = ST_DONE;
                    else if (trailing_ones != '0)
                        state_nxt = ST_T1S;
                    else
                        state_nxt = ST_PREFIX;
                end
            end
            ST_T1S:    if (ena) state_nxt = all_t1s ? ST_DONE : ST_PREFIX;
            ST_PREFIX: if (ena) state_nxt = ST_SUFFIX;
            ST_SUFFIX: if (ena) state_nxt = ST_CALC;
            ST_CALC:   if (ena) state_nxt = (i == '0) ? ST_DONE : ST_PREFIX;
            ST_DONE:   state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // ----------------------------------------------------------------------
    // counts and coefficient index
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_total_coeff   <= '0;
            blk_trailing_ones <= '0;
        end else if (start_ok) begin
            blk_total_coeff   <= total_coeff;
            blk_trailing_ones <= trailing_ones;
        end
    end

    // highest index first, levels are sent in reverse scan order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            i <= '0;
        else if (start_ok)
            i <= coeff_idx_t'(total_coeff - 5'd1);
        else if (t1s_sel && ena)
            i <= coeff_idx_t'(blk_total_coeff - coeff_cnt_t'(blk_trailing_ones) - 5'd1);
        else if (calc_sel && ena && i != '0)
            i <= i - 1'b1;
    end

    // ----------------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------------

    assign t1s_sel    = state == ST_T1S;
    assign prefix_sel = state == ST_PREFIX;
    assign suffix_sel = state == ST_SUFFIX;
    assign calc_sel   = state == ST_CALC;
    assign ena        = (t1s_sel || prefix_sel || suffix_sel || calc_sel) && bits_ok;
    assign clear      = start_ok;
    assign busy       = state != ST_IDLE;
    assign done       = state == ST_DONE;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot(state))
        else $error("level FSM state not one-hot");

    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("start while a block is still being decoded");

endmodule

`default_nettype wire

// File: cavlc_bit_window.sv
`default_nettype none

`include "cavlc_defines.svh"

module cavlc_bit_window (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CAVLC_WIN_W-1:0]   word,
    input  logic                      word_wr,
    input  logic                      ena,
    input  cavlc_pkg::len_t           len_comb,
    output logic [0:`CAVLC_WIN_W-1]   bits,
    output logic                      bits_ok,
    output logic                      space
);

    localparam int FILL_W = $clog2(`CAVLC_BUF_W + 1);
    localparam int PAD_W  = `CAVLC_BUF_W - `CAVLC_WIN_W;

    // valid bits sit left-aligned from index 0
    logic [0:`CAVLC_BUF_W-1] win_buf;
    logic [FILL_W-1:0]       fill;

    logic [FILL_W-1:0]       len_eff;
    logic [FILL_W-1:0]       fill_drop;
    logic [0:`CAVLC_BUF_W-1] shifted;
    logic [0:`CAVLC_BUF_W-1] appended;

    // ----------------------------------------------------------------------
    // consume and append
    // ----------------------------------------------------------------------

    always_comb begin
        len_eff   = ena ? FILL_W'(len_comb) : '0;
        fill_drop = fill - len_eff;
        shifted   = win_buf << len_eff;
        // new word lands right behind what is left after the drop
        appended  = {word, {PAD_W{1'b0}}} >> fill_drop;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_buf <= '0;
            fill    <= '0;
        end else if (word_wr) begin
            win_buf <= shifted | appended;
            fill    <= fill_drop + FILL_W'(`CAVLC_WIN_W);
        end else begin
            win_buf <= shifted;
            fill    <= fill_drop;
        end
    end

    assign bits    = win_buf[0:`CAVLC_WIN_W-1];
    assign bits_ok = fill >= FILL_W'(`CAVLC_WIN_W);
    assign space   = fill <= FILL_W'(PAD_W);

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    // a word written without room would overrun the buffer
    assert property (@(posedge clk) disable iff (!rst_n) word_wr |-> space)
        else $error("word written to a full bit window");

    // the reader never asks for bits that have not arrived
    assert property (@(posedge clk) disable iff (!rst_n)
        ena |-> FILL_W'(len_comb) <= fill)
        else $error("len_comb %0d exceeds fill %0d", len_comb, fill);

endmodule

`default_nettype wire

// File: cavlc_pkg.sv
`default_nettype none

`include "cavlc_defines.svh"

package cavlc_pkg;

    // signed coefficient level
    typedef logic signed [`CAVLC_LEVEL_W-1:0] level_t;

    typedef logic [$clog2(`CAVLC_MAX_COEFF+1)-1:0] coeff_cnt_t;
    typedef logic [1:0] t1_cnt_t;
    typedef logic [$clog2(`CAVLC_MAX_COEFF)-1:0] coeff_idx_t;

    // bits dropped from the window in one step
    typedef logic [$clog2(`CAVLC_WIN_W+1)-1:0] len_t;

    // one-hot level reader states
    typedef enum logic [5:0] {
        ST_IDLE   = 6'b000001,
        ST_T1S    = 6'b000010,
        ST_PREFIX = 6'b000100,
        ST_SUFFIX = 6'b001000,
        ST_CALC   = 6'b010000,
        ST_DONE   = 6'b100000
    } lvl_state_t;

endpackage

`default_nettype wire

// File: cavlc_defines.svh
`ifndef CAVLC_DEFINES_SVH
`define CAVLC_DEFINES_SVH

// ----------------------------------------------------------------------
// bitstream window
// ----------------------------------------------------------------------

// bits presented to the level reader per step
`define CAVLC_WIN_W 16

// three words of buffering behind the window
`define CAVLC_BUF_W 48

// ----------------------------------------------------------------------
// residual block
// ----------------------------------------------------------------------

`define CAVLC_LEVEL_W 9

`define CAVLC_MAX_COEFF 16

`endif
